/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := decodeClusterTb
FILELIST  := sim.f
OBJDIR    := obj_dir

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJDIR)

/* logic/aluDecoder.sv */
`timescale 1ns/100ps

module aluDecoder (
	input  logic [1:0] aluOp,
	input  logic [2:0] funct3,
	input  logic funct7b5,
	input  logic opIsRType,
	output decodePkg::aluCtrl_t aluControl
);
	import decodePkg::*;

	always_comb begin
		case (aluOp)
			AluOpAdd: aluControl = AluAdd;    // Loads, stores, jal
			AluOpBranch: begin
				case (funct3)
					3'b100, 3'b101: aluControl = AluSlt;    // blt, bge
					3'b110, 3'b111: aluControl = AluSltu;   // bltu, bgeu
					default:        aluControl = AluSub;    // beq, bne
				endcase
			end
			AluOpLui: aluControl = AluPassB;
			default: begin
				case (funct3)
					// Bit 30 of addi is immediate, so sub only for R-type
					3'b000:  aluControl = (opIsRType && funct7b5) ? AluSub : AluAdd;
					3'b001:  aluControl = AluSll;
					3'b010:  aluControl = AluSlt;
					3'b011:  aluControl = AluSltu;
					3'b100:  aluControl = AluXor;
					3'b101:  aluControl = funct7b5 ? AluSra : AluSrl;
					3'b110:  aluControl = AluOr;
					default: aluControl = AluAnd;
				endcase
			end
		endcase
	end

endmodule

/* logic/decodeCluster.sv */
`timescale 1ns/100ps

module decodeCluster (
	input  logic clk,
	input  logic reset,
	input  logic inReq,
	input  decodePkg::instrWord_u instr,
	input  logic outAck,
	input  logic regWrite,
	input  logic [decodePkg::RegIdxW-1:0] wbRd,
	input  logic [decodePkg::XLen-1:0] resultData,
	output logic inAck,
	output logic outReq,
	output logic [decodePkg::RegIdxW-1:0] outRd,
	output logic [decodePkg::XLen-1:0] outRs1Data,
	output logic [decodePkg::XLen-1:0] outRs2Data,
	output logic [decodePkg::XLen-1:0] outImm,
	output decodePkg::aluCtrl_t outAluControl,
	output logic outAluSrcImm,
	output logic outRegWrite,
	output logic outMemWrite,
	output logic outBranch,
	output logic outJump,
	output logic outIllegal
);
	import decodePkg::*;

	logic [NumLanes-1:0] laneReq;
	logic [NumLanes-1:0] laneAck;
	instrWord_u laneInstr;           // Shared by all lanes
	logic [NumLanes-1:0] doneReq;
	logic [NumLanes-1:0] doneAck;
	logic [RegIdxW-1:0] laneRd [NumLanes];
	logic [RegIdxW-1:0] laneRs1 [NumLanes];
	logic [RegIdxW-1:0] laneRs2 [NumLanes];
	logic [XLen-1:0] laneImm [NumLanes];
	aluCtrl_t laneAluControl [NumLanes];
	logic [NumLanes-1:0] laneAluSrcImm;
	logic [NumLanes-1:0] laneRegWrite;
	logic [NumLanes-1:0] laneMemWrite;
	logic [NumLanes-1:0] laneBranch;
	logic [NumLanes-1:0] laneJump;
	logic [NumLanes-1:0] laneIllegal;
	logic [RegIdxW-1:0] rdAddr1;
	logic [RegIdxW-1:0] rdAddr2;
	logic [XLen-1:0] rdData1;
	logic [XLen-1:0] rdData2;

	instrDispatch instrDispatch_i (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.instr(instr),
		.laneAck(laneAck),
		.inAck(inAck),
		.laneReq(laneReq),
		.laneInstr(laneInstr)
	);

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		instructionDecoder instructionDecoder_i (
			.clk(clk),
			.reset(reset),
			.laneReq(laneReq[i]),
			.laneInstr(laneInstr),
			.doneAck(doneAck[i]),
			.laneAck(laneAck[i]),
			.doneReq(doneReq[i]),
			.rd(laneRd[i]),
			.rs1(laneRs1[i]),
			.rs2(laneRs2[i]),
			.immExt(laneImm[i]),
			.aluControl(laneAluControl[i]),
			.aluSrcImm(laneAluSrcImm[i]),
			.regWrite(laneRegWrite[i]),
			.memWrite(laneMemWrite[i]),
			.branch(laneBranch[i]),
			.jump(laneJump[i]),
			.illegal(laneIllegal[i])
		);
	end

	decodeCollector decodeCollector_i (
		.clk(clk),
		.reset(reset),
		.doneReq(doneReq),
		.laneRd(laneRd),
		.laneRs1(laneRs1),
		.laneRs2(laneRs2),
		.laneImm(laneImm),
		.laneAluControl(laneAluControl),
		.laneAluSrcImm(laneAluSrcImm),
		.laneRegWrite(laneRegWrite),
		.laneMemWrite(laneMemWrite),
		.laneBranch(laneBranch),
		.laneJump(laneJump),
		.laneIllegal(laneIllegal),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.outAck(outAck),
		.doneAck(doneAck),
		.rdAddr1(rdAddr1),
		.rdAddr2(rdAddr2),
		.outReq(outReq),
		.outRd(outRd),
		.outRs1Data(outRs1Data),
		.outRs2Data(outRs2Data),
		.outImm(outImm),
		.outAluControl(outAluControl),
		.outAluSrcImm(outAluSrcImm),
		.outRegWrite(outRegWrite),
		.outMemWrite(outMemWrite),
		.outBranch(outBranch),
		.outJump(outJump),
		.outIllegal(outIllegal)
	);

	// Write port is the outside writeback path
	registerFile registerFile_i (
		.clk(clk),
		.reset(reset),
		.rdAddr1(rdAddr1),
		.rdAddr2(rdAddr2),
		.wrAddr(wbRd),
		.wrEn(regWrite),
		.wrData(resultData),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

endmodule

/* logic/decodeCollector.sv */
`timescale 1ns/100ps

module decodeCollector (
	input  logic clk,
	input  logic reset,
	input  logic [decodePkg::NumLanes-1:0] doneReq,
	input  logic [decodePkg::RegIdxW-1:0] laneRd [decodePkg::NumLanes],
	input  logic [decodePkg::RegIdxW-1:0] laneRs1 [decodePkg::NumLanes],
	input  logic [decodePkg::RegIdxW-1:0] laneRs2 [decodePkg::NumLanes],
	input  logic [decodePkg::XLen-1:0] laneImm [decodePkg::NumLanes],
	input  decodePkg::aluCtrl_t laneAluControl [decodePkg::NumLanes],
	input  logic [decodePkg::NumLanes-1:0] laneAluSrcImm,
	input  logic [decodePkg::NumLanes-1:0] laneRegWrite,
	input  logic [decodePkg::NumLanes-1:0] laneMemWrite,
	input  logic [decodePkg::NumLanes-1:0] laneBranch,
	input  logic [decodePkg::NumLanes-1:0] laneJump,
	input  logic [decodePkg::NumLanes-1:0] laneIllegal,
	input  logic [decodePkg::XLen-1:0] rdData1,
	input  logic [decodePkg::XLen-1:0] rdData2,
	input  logic outAck,
	output logic [decodePkg::NumLanes-1:0] doneAck,
	output logic [decodePkg::RegIdxW-1:0] rdAddr1,
	output logic [decodePkg::RegIdxW-1:0] rdAddr2,
	output logic outReq,
	output logic [decodePkg::RegIdxW-1:0] outRd,
	output logic [decodePkg::XLen-1:0] outRs1Data,
	output logic [decodePkg::XLen-1:0] outRs2Data,
	output logic [decodePkg::XLen-1:0] outImm,
	output decodePkg::aluCtrl_t outAluControl,
	output logic outAluSrcImm,
	output logic outRegWrite,
	output logic outMemWrite,
	output logic outBranch,
	output logic outJump,
	output logic outIllegal
);
	import decodePkg::*;

	enum logic [1:0] {CollIdle, CollDeliver, CollRelease} state;

	logic [LaneIdxW-1:0] expectLane;   // Oldest lane in program order
	logic take;

	// Operands are read at collection, not at decode
	assign rdAddr1 = laneRs1[expectLane];
	assign rdAddr2 = laneRs2[expectLane];
	assign take = (state == CollIdle) && doneReq[expectLane];

	always_ff @(posedge clk) begin
		if (take) begin
			outRd <= laneRd[expectLane];
			outRs1Data <= rdData1;
			outRs2Data <= rdData2;
			outImm <= laneImm[expectLane];
			outAluControl <= laneAluControl[expectLane];
			outAluSrcImm <= laneAluSrcImm[expectLane];
			outRegWrite <= laneRegWrite[expectLane];
			outMemWrite <= laneMemWrite[expectLane];
			outBranch <= laneBranch[expectLane];
			outJump <= laneJump[expectLane];
			outIllegal <= laneIllegal[expectLane];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CollIdle;
			doneAck <= '0;
			outReq <= 1'b0;
			expectLane <= '0;
		end else begin
			case (state)
				CollIdle: begin
					if (take) begin
						doneAck[expectLane] <= 1'b1;
						outReq <= 1'b1;
						state <= CollDeliver;
					end
				end
				CollDeliver: begin
					if (outAck) begin
						outReq <= 1'b0;
						state <= CollRelease;
					end
				end
				CollRelease: begin
					// Both handshakes must close before moving on
					if (!doneReq[expectLane] && !outAck) begin
						doneAck <= '0;
						expectLane <= (expectLane == LaneIdxW'(NumLanes - 1)) ? '0 : expectLane + 1'b1;
						state <= CollIdle;
					end
				end
				default: state <= CollIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		outReq && !outAck |=> outReq && $stable(outImm) && $stable(outRs1Data))
		else $error("Bundle dropped or changed before outAck");

endmodule

/* logic/decodePkg.sv */
package decodePkg;

	localparam int XLen = 32;
	localparam int NumLanes = 3;                   // Decode lanes, 2 or more
	localparam int LaneIdxW = $clog2(NumLanes);
	localparam int RegIdxW = 5;

	// RV32I major opcodes handled by the lanes
	localparam logic [6:0] OpRType  = 7'b0110011;
	localparam logic [6:0] OpIAlu   = 7'b0010011;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpLui    = 7'b0110111;
	localparam logic [6:0] OpJal    = 7'b1101111;

	typedef logic [3:0] aluCtrl_t;

	localparam aluCtrl_t AluAdd   = 4'd0;
	localparam aluCtrl_t AluSub   = 4'd1;
	localparam aluCtrl_t AluAnd   = 4'd2;
	localparam aluCtrl_t AluOr    = 4'd3;
	localparam aluCtrl_t AluXor   = 4'd4;
	localparam aluCtrl_t AluSlt   = 4'd5;
	localparam aluCtrl_t AluSltu  = 4'd6;
	localparam aluCtrl_t AluSll   = 4'd7;
	localparam aluCtrl_t AluSrl   = 4'd8;
	localparam aluCtrl_t AluSra   = 4'd9;
	localparam aluCtrl_t AluPassB = 4'd10;       // Immediate straight through, for lui

	// Operation class, lane to ALU decoder
	localparam logic [1:0] AluOpAdd    = 2'd0;
	localparam logic [1:0] AluOpBranch = 2'd1;
	localparam logic [1:0] AluOpFunct  = 2'd2;
	localparam logic [1:0] AluOpLui    = 2'd3;

	// One instruction word, six format views over the same bits
	typedef union packed {
		struct packed {
			logic [6:0]         funct7;
			logic [RegIdxW-1:0] rs2;
			logic [RegIdxW-1:0] rs1;
			logic [2:0]         funct3;
			logic [RegIdxW-1:0] rd;
			logic [6:0]         opcode;
		} rType;
		struct packed {
			logic [11:0]        imm11_0;
			logic [RegIdxW-1:0] rs1;
			logic [2:0]         funct3;
			logic [RegIdxW-1:0] rd;
			logic [6:0]         opcode;
		} iType;
		struct packed {
			logic [6:0]         imm11_5;
			logic [RegIdxW-1:0] rs2;
			logic [RegIdxW-1:0] rs1;
			logic [2:0]         funct3;
			logic [4:0]         imm4_0;
			logic [6:0]         opcode;
		} sType;
		struct packed {
			logic               imm12;
			logic [5:0]         imm10_5;
			logic [RegIdxW-1:0] rs2;
			logic [RegIdxW-1:0] rs1;
			logic [2:0]         funct3;
			logic [3:0]         imm4_1;
			logic               imm11;
			logic [6:0]         opcode;
		} bType;
		struct packed {
			logic [19:0]        imm31_12;
			logic [RegIdxW-1:0] rd;
			logic [6:0]         opcode;
		} uType;
		struct packed {
			logic               imm20;
			logic [9:0]         imm10_1;
			logic               imm11;
			logic [7:0]         imm19_12;
			logic [RegIdxW-1:0] rd;
			logic [6:0]         opcode;
		} jType;
	} instrWord_u;

endpackage

/* logic/instrDispatch.sv */
`timescale 1ns/100ps

module instrDispatch (
	input  logic clk,
	input  logic reset,
	input  logic inReq,
	input  decodePkg::instrWord_u instr,
	input  logic [decodePkg::NumLanes-1:0] laneAck,
	output logic inAck,
	output logic [decodePkg::NumLanes-1:0] laneReq,
	output decodePkg::instrWord_u laneInstr
);
	import decodePkg::*;

	enum logic [1:0] {DispIdle, DispLaneWait, DispRelease} state;

	logic [LaneIdxW-1:0] nextLane;   // Round-robin pointer
	logic load;

	// A lane still acking its last word is not free yet
	assign load = (state == DispIdle) && inReq && !laneAck[nextLane];

	always_ff @(posedge clk) begin
		if (load)
			laneInstr <= instr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DispIdle;
			inAck <= 1'b0;
			laneReq <= '0;
			nextLane <= '0;
		end else begin
			case (state)
				DispIdle: begin
					if (load) begin
						laneReq[nextLane] <= 1'b1;
						state <= DispLaneWait;
					end
				end
				DispLaneWait: begin
					// Busy lane never acks, so this is where back-pressure stalls
					if (laneAck[nextLane]) begin
						laneReq <= '0;
						inAck <= 1'b1;
						state <= DispRelease;
					end
				end
				DispRelease: begin
					if (!inReq) begin
						inAck <= 1'b0;
						nextLane <= (nextLane == LaneIdxW'(NumLanes - 1)) ? '0 : nextLane + 1'b1;
						state <= DispIdle;
					end
				end
				default: state <= DispIdle;
			endcase
		end
	end

	for (genvar g = 0; g < NumLanes; g++) begin : gReqHold
		assert property (@(posedge clk) disable iff (reset)
			laneReq[g] && !laneAck[g] |=> laneReq[g])
			else $error("laneReq[%0d] dropped before its laneAck", g);
	end

endmodule

/* logic/instructionDecoder.sv */
`timescale 1ns/100ps

module instructionDecoder (
	input  logic clk,
	input  logic reset,
	input  logic laneReq,
	input  decodePkg::instrWord_u laneInstr,
	input  logic doneAck,
	output logic laneAck,
	output logic doneReq,
	output logic [decodePkg::RegIdxW-1:0] rd,
	output logic [decodePkg::RegIdxW-1:0] rs1,
	output logic [decodePkg::RegIdxW-1:0] rs2,
	output logic [decodePkg::XLen-1:0] immExt,
	output decodePkg::aluCtrl_t aluControl,
	output logic aluSrcImm,
	output logic regWrite,
	output logic memWrite,
	output logic branch,
	output logic jump,
	output logic illegal
);
	import decodePkg::*;

	enum logic [1:0] {LaneIdle, LaneDecode, LaneHold, LaneRelease} state;

	instrWord_u wordQ;                 // Word under decode
	logic accept;
	logic [RegIdxW-1:0] rdD;
	logic [RegIdxW-1:0] rs1D;
	logic [RegIdxW-1:0] rs2D;
	logic [XLen-1:0] immD;
	logic [1:0] aluOp;
	aluCtrl_t aluControlD;
	logic aluSrcImmD;
	logic regWriteD;
	logic memWriteD;
	logic branchD;
	logic jumpD;
	logic illegalD;

	assign accept = (state == LaneIdle) && laneReq && !laneAck;

	// Opcode picks the view; unused indices stay zero
	always_comb begin
		rdD = '0;
		rs1D = '0;
		rs2D = '0;
		immD = '0;
		aluOp = AluOpAdd;
		aluSrcImmD = 1'b0;
		regWriteD = 1'b0;
		memWriteD = 1'b0;
		branchD = 1'b0;
		jumpD = 1'b0;
		illegalD = 1'b0;
		case (wordQ.rType.opcode)
			OpRType: begin
				rdD = wordQ.rType.rd;
				rs1D = wordQ.rType.rs1;
				rs2D = wordQ.rType.rs2;
				aluOp = AluOpFunct;
				regWriteD = 1'b1;
			end
			OpIAlu, OpLoad: begin
				rdD = wordQ.iType.rd;
				rs1D = wordQ.iType.rs1;
				immD = {{(XLen-12){wordQ.iType.imm11_0[11]}}, wordQ.iType.imm11_0};
				aluOp = (wordQ.iType.opcode == OpIAlu) ? AluOpFunct : AluOpAdd;
				aluSrcImmD = 1'b1;
				regWriteD = 1'b1;
			end
			OpStore: begin
				rs1D = wordQ.sType.rs1;
				rs2D = wordQ.sType.rs2;
				immD = {{(XLen-12){wordQ.sType.imm11_5[6]}}, wordQ.sType.imm11_5, wordQ.sType.imm4_0};
				aluSrcImmD = 1'b1;          // Address is base plus offset
				memWriteD = 1'b1;
			end
			OpBranch: begin
				rs1D = wordQ.bType.rs1;
				rs2D = wordQ.bType.rs2;
				immD = {{(XLen-12){wordQ.bType.imm12}}, wordQ.bType.imm11, wordQ.bType.imm10_5,
					wordQ.bType.imm4_1, 1'b0};
				aluOp = AluOpBranch;
				branchD = 1'b1;
			end
			OpLui: begin
				rdD = wordQ.uType.rd;
				immD = {wordQ.uType.imm31_12, 12'b0};
				aluOp = AluOpLui;
				aluSrcImmD = 1'b1;
				regWriteD = 1'b1;
			end
			OpJal: begin
				rdD = wordQ.jType.rd;
				immD = {{(XLen-20){wordQ.jType.imm20}}, wordQ.jType.imm19_12, wordQ.jType.imm11,
					wordQ.jType.imm10_1, 1'b0};
				regWriteD = 1'b1;           // Link register
				jumpD = 1'b1;
			end
			default: illegalD = 1'b1;
		endcase
	end

	aluDecoder aluDecoder_i (
		.aluOp(aluOp),
		.funct3(wordQ.rType.funct3),
		.funct7b5(wordQ.rType.funct7[5]),
		.opIsRType(wordQ.rType.opcode == OpRType),
		.aluControl(aluControlD)
	);

	always_ff @(posedge clk) begin
		if (accept)
			wordQ <= laneInstr;
		if (state == LaneDecode) begin
			rd <= rdD;
			rs1 <= rs1D;
			rs2 <= rs2D;
			immExt <= immD;
			aluControl <= aluControlD;
			aluSrcImm <= aluSrcImmD;
			regWrite <= regWriteD;
			memWrite <= memWriteD;
			branch <= branchD;
			jump <= jumpD;
			illegal <= illegalD;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LaneIdle;
			laneAck <= 1'b0;
			doneReq <= 1'b0;
		end else begin
			if (accept)
				laneAck <= 1'b1;
			else if (laneAck && !laneReq)
				laneAck <= 1'b0;            // Dispatcher has let go
			case (state)
				LaneIdle:    if (accept) state <= LaneDecode;
				LaneDecode: begin
					doneReq <= 1'b1;
					state <= LaneHold;
				end
				LaneHold: begin
					if (doneAck) begin
						doneReq <= 1'b0;
						state <= LaneRelease;
					end
				end
				LaneRelease: if (!doneAck) state <= LaneIdle;
				default:     state <= LaneIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) $rose(doneReq) |-> !doneAck)
		else $error("doneReq rose while the collector still held doneAck");

endmodule

/* logic/registerFile.sv */
`timescale 1ns/100ps

module registerFile (
	input  logic clk,
	input  logic reset,
	input  logic [decodePkg::RegIdxW-1:0] rdAddr1,
	input  logic [decodePkg::RegIdxW-1:0] rdAddr2,
	input  logic [decodePkg::RegIdxW-1:0] wrAddr,
	input  logic wrEn,
	input  logic [decodePkg::XLen-1:0] wrData,
	output logic [decodePkg::XLen-1:0] rdData1,
	output logic [decodePkg::XLen-1:0] rdData2
);
	import decodePkg::*;

	logic [XLen-1:0] regs [2**RegIdxW];

	// Writeback port; x0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 2**RegIdxW; r++)
				regs[r] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdData1 = regs[rdAddr1];
	assign rdData2 = regs[rdAddr2];

	assert property (@(posedge clk) disable iff (reset) rdAddr1 == '0 |-> rdData1 == '0)
		else $error("x0 read back nonzero");

endmodule

/* sim.f */
+incdir+testbench
logic/decodePkg.sv
logic/aluDecoder.sv
logic/registerFile.sv
logic/instrDispatch.sv
logic/instructionDecoder.sv
logic/decodeCollector.sv
logic/decodeCluster.sv
testbench/decodeClusterTb.sv

/* testbench/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] rngState = 32'd29329;
logic [XLen-1:0] modelRegs [32];    // Mirror of the register file

// xorshift32
function automatic logic [31:0] nextRand();
	logic [31:0] x;
	x = rngState;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rngState = x;
	return x;
endfunction

function automatic logic isKnownOp(input logic [6:0] op);
	return op inside {OpRType, OpIAlu, OpLoad, OpStore, OpBranch, OpLui, OpJal};
endfunction

// Random fields, opcode forced to one of the seven or to an unknown one
function automatic logic [31:0] buildInstr();
	logic [31:0] w;
	logic [2:0] pick;
	logic [6:0] op;
	w = nextRand();
	pick = 3'(nextRand());
	case (pick)
		3'd0: op = OpRType;
		3'd1: op = OpIAlu;
		3'd2: op = OpLoad;
		3'd3: op = OpStore;
		3'd4: op = OpBranch;
		3'd5: op = OpLui;
		3'd6: op = OpJal;
		default: begin
			op = w[6:0];
			while (isKnownOp(op))
				op = op + 7'd1;      // Step off decoded opcodes
		end
	endcase
	w[6:0] = op;
	return w;
endfunction

function automatic aluCtrl_t functAlu(input logic [2:0] f3, input logic b30, input logic isR);
	case (f3)
		3'b000:  return (isR && b30) ? AluSub : AluAdd;
		3'b001:  return AluSll;
		3'b010:  return AluSlt;
		3'b011:  return AluSltu;
		3'b100:  return AluXor;
		3'b101:  return b30 ? AluSra : AluSrl;
		3'b110:  return AluOr;
		default: return AluAnd;
	endcase
endfunction

// Flags packed as {aluSrcImm, regWrite, memWrite, branch, jump, illegal}
function automatic void refDecode(
	input  logic [31:0] w,
	output logic [RegIdxW-1:0] rd,
	output logic [RegIdxW-1:0] rs1,
	output logic [RegIdxW-1:0] rs2,
	output logic [XLen-1:0] imm,
	output aluCtrl_t alu,
	output logic [5:0] flags
);
	rd = '0;
	rs1 = '0;
	rs2 = '0;
	imm = '0;
	alu = AluAdd;
	flags = '0;
	case (w[6:0])
		OpRType: begin
			rd = w[11:7];
			rs1 = w[19:15];
			rs2 = w[24:20];
			alu = functAlu(w[14:12], w[30], 1'b1);
			flags = 6'b010000;
		end
		OpIAlu, OpLoad: begin
			rd = w[11:7];
			rs1 = w[19:15];
			imm = {{20{w[31]}}, w[31:20]};
			if (w[6:0] == OpIAlu)
				alu = functAlu(w[14:12], w[30], 1'b0);
			flags = 6'b110000;
		end
		OpStore: begin
			rs1 = w[19:15];
			rs2 = w[24:20];
			imm = {{20{w[31]}}, w[31:25], w[11:7]};
			flags = 6'b101000;
		end
		OpBranch: begin
			rs1 = w[19:15];
			rs2 = w[24:20];
			imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			if (w[14:13] == 2'b10)
				alu = AluSlt;           // blt, bge
			else if (w[14:13] == 2'b11)
				alu = AluSltu;
			else
				alu = AluSub;
			flags = 6'b000100;
		end
		OpLui: begin
			rd = w[11:7];
			imm = {w[31:12], 12'b0};
			alu = AluPassB;
			flags = 6'b110000;
		end
		OpJal: begin
			rd = w[11:7];
			imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			flags = 6'b010010;
		end
		default: flags = 6'b000001;
	endcase
endfunction

`endif

/* testbench/decodeClusterTb.sv */
`timescale 1ns/100ps

module decodeClusterTb;
	import decodePkg::*;

	localparam int NumInstr = 300;
	localparam int NumSkew = NumLanes - 1 - (NumInstr % NumLanes);  // Lane pointers end on the last lane
	localparam int NumAfterReset = 20;
	localparam real WatchdogNs = ((NumInstr + NumSkew + NumAfterReset) * 40 + 2000) * 8.0;

	logic clk;
	logic reset;
	logic inReq;
	instrWord_u instr;
	logic outAck;
	logic regWrite;
	logic [RegIdxW-1:0] wbRd;
	logic [XLen-1:0] resultData;
	logic inAck;
	logic outReq;
	logic [RegIdxW-1:0] outRd;
	logic [XLen-1:0] outRs1Data;
	logic [XLen-1:0] outRs2Data;
	logic [XLen-1:0] outImm;
	aluCtrl_t outAluControl;
	logic outAluSrcImm;
	logic outRegWrite;
	logic outMemWrite;
	logic outBranch;
	logic outJump;
	logic outIllegal;

	int errorCount = 0;
	int checkCount = 0;
	int acceptedCount;
	int deliveredCount;
	logic [31:0] expectedQ [$];        // Words in acceptance order
	logic [31:0] curWord;
	logic [RegIdxW-1:0] gotRd;
	logic [XLen-1:0] gotRs1Data;
	logic [XLen-1:0] gotRs2Data;
	logic [XLen-1:0] gotImm;
	aluCtrl_t gotAlu;
	logic [5:0] gotFlags;

	`include "decodeModel.svh"

	decodeCluster decodeCluster_i (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.instr(instr),
		.outAck(outAck),
		.regWrite(regWrite),
		.wbRd(wbRd),
		.resultData(resultData),
		.inAck(inAck),
		.outReq(outReq),
		.outRd(outRd),
		.outRs1Data(outRs1Data),
		.outRs2Data(outRs2Data),
		.outImm(outImm),
		.outAluControl(outAluControl),
		.outAluSrcImm(outAluSrcImm),
		.outRegWrite(outRegWrite),
		.outMemWrite(outMemWrite),
		.outBranch(outBranch),
		.outJump(outJump),
		.outIllegal(outIllegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(WatchdogNs);
		$display("Run timed out at %0t: a handshake never completed", $time);
		$display("Result: FAILED");
		$finish;
	end

	task automatic compareWord(input string what, input logic [XLen-1:0] got,
		input logic [XLen-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t: %s is %h, expected %h (instr %h)", $time, what, got, exp, curWord);
		end
	endtask

	task automatic compareAlu(input string what, input aluCtrl_t got, input aluCtrl_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t: %s is %0d, expected %0d (instr %h)", $time, what, got, exp, curWord);
		end
	endtask

	task automatic compareFlag(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t: %s is %b, expected %b (instr %h)", $time, what, got, exp, curWord);
		end
	endtask

	// Inputs change and outputs are sampled 1 ns after the edge
	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		inReq = 1'b0;
		outAck = 1'b0;
		regWrite = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		curWord = '0;
		compareFlag("inAck after reset", inAck, 1'b0);
		compareFlag("outReq after reset", outReq, 1'b0);
	endtask

	task automatic writeRegs(input int count);
		logic [RegIdxW-1:0] addr;
		logic [XLen-1:0] data;
		for (int k = 0; k < count; k++) begin
			addr = (k == 0) ? '0 : RegIdxW'(nextRand());   // First write aims at x0
			data = nextRand();
			waitCycle();
			regWrite = 1'b1;
			wbRd = addr;
			resultData = data;
			if (addr != '0)
				modelRegs[addr] = data;     // x0 keeps zero
		end
		waitCycle();
		regWrite = 1'b0;
	endtask

	function automatic int pickAckDelay();
		logic [31:0] r;
		r = nextRand();
		if (r[2:0] == 3'd0)
			return 12 + int'(r[12:8]);     // Long stall so the lanes fill
		return int'(r[9:8]);
	endfunction

	task automatic sendInstrs(input int count);
		logic [31:0] w;
		for (int k = 0; k < count; k++) begin
			w = buildInstr();
			instr = w;
			inReq = 1'b1;
			waitCycle();
			while (!inAck)
				waitCycle();
			expectedQ.push_back(w);
			acceptedCount++;
			checkCount++;
			if (acceptedCount - deliveredCount > NumLanes + 1) begin
				errorCount++;
				$display("[FAIL] %0t: %0d items accepted beyond the last delivered one",
					$time, acceptedCount - deliveredCount);
			end
			inReq = 1'b0;
			waitCycle();
			while (inAck)
				waitCycle();
		end
	endtask

	task automatic captureBundle();
		gotRd = outRd;
		gotRs1Data = outRs1Data;
		gotRs2Data = outRs2Data;
		gotImm = outImm;
		gotAlu = outAluControl;
		gotFlags = {outAluSrcImm, outRegWrite, outMemWrite, outBranch, outJump, outIllegal};
	endtask

	task automatic checkHeld();
		compareFlag("outReq before outAck", outReq, 1'b1);
		compareWord("held rs1 operand", outRs1Data, gotRs1Data);
		compareWord("held rs2 operand", outRs2Data, gotRs2Data);
		compareWord("held immediate", outImm, gotImm);
		compareWord("held control fields",
			XLen'({outRd, outAluControl, outAluSrcImm, outRegWrite, outMemWrite,
				outBranch, outJump, outIllegal}),
			XLen'({gotRd, gotAlu, gotFlags}));
	endtask

	task automatic checkExpected(input logic [31:0] w);
		logic [RegIdxW-1:0] rd;
		logic [RegIdxW-1:0] rs1;
		logic [RegIdxW-1:0] rs2;
		logic [XLen-1:0] imm;
		aluCtrl_t alu;
		logic [5:0] flags;
		curWord = w;
		refDecode(w, rd, rs1, rs2, imm, alu, flags);
		compareWord("rd", XLen'(gotRd), XLen'(rd));
		compareWord("rs1 operand", gotRs1Data, modelRegs[rs1]);
		compareWord("rs2 operand", gotRs2Data, modelRegs[rs2]);
		compareWord("immediate", gotImm, imm);
		if (!flags[0])
			compareAlu("ALU control", gotAlu, alu);
		compareFlag("aluSrcImm", gotFlags[5], flags[5]);
		compareFlag("regWrite", gotFlags[4], flags[4]);
		compareFlag("memWrite", gotFlags[3], flags[3]);
		compareFlag("branch", gotFlags[2], flags[2]);
		compareFlag("jump", gotFlags[1], flags[1]);
		compareFlag("illegal", gotFlags[0], flags[0]);
	endtask

	task automatic receiveBundles(input int count);
		int hold;
		for (int k = 0; k < count; k++) begin
			while (!outReq)
				waitCycle();
			captureBundle();
			deliveredCount++;
			hold = pickAckDelay();
			for (int c = 0; c < hold; c++) begin
				waitCycle();
				checkHeld();
			end
			if (expectedQ.size() == 0) begin
				errorCount++;
				$display("A bundle came out at %0t with no instruction accepted", $time);
			end else begin
				checkExpected(expectedQ.pop_front());
			end
			outAck = 1'b1;
			waitCycle();
			while (outReq)
				waitCycle();
			outAck = 1'b0;
		end
	endtask

	task automatic runPhase(input int count);
		acceptedCount = 0;
		deliveredCount = 0;
		fork
			sendInstrs(count);
			receiveBundles(count);
		join
		if (expectedQ.size() != 0) begin
			errorCount++;
			$display("%0d accepted instructions never came out", expectedQ.size());
		end
	endtask

	initial begin
		reset = 1'b1;
		inReq = 1'b0;
		instr = '0;
		outAck = 1'b0;
		regWrite = 1'b0;
		wbRd = '0;
		resultData = '0;
		applyReset();
		writeRegs(20);
		runPhase(NumInstr);
		runPhase(NumSkew);
		// Second reset with both lane pointers off zero
		applyReset();
		writeRegs(8);
		runPhase(NumAfterReset);
		waitCycle();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
